// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= compile.f
TB_TOP     ?= tb_id_stage
RTL_TOP    ?= id_stage
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing
LINT_FLAGS ?= -Wall
PASS_MSG   ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
hdl/decode_pkg.sv
hdl/inst_decoder.sv
hdl/operand_fwd.sv
hdl/branch_resolve.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
verif/tb_id_stage.sv

// ==== hdl/branch_resolve.sv ====
`timescale 1ns/1ns

module branch_resolve (
	input  decode_pkg::br_ctrl_t br_ctrl_i,
	input  decode_pkg::word_t    a_i,
	input  decode_pkg::word_t    b_i,
	input  decode_pkg::word_t    c_i,
	output decode_pkg::br_out_t  br_o
);

	import decode_pkg::*;

	logic a_eq_b;
	logic a_lt_b;

	// unsigned compare only
	assign a_eq_b = (a_i == b_i);
	assign a_lt_b = (a_i < b_i);

	always_comb begin
		case (br_ctrl_i.kind)
			BR_ALWAYS: br_o.taken = 1'b1;
			BR_EQ:     br_o.taken = a_eq_b;
			BR_NE:     br_o.taken = !a_eq_b;
			BR_GT:     br_o.taken = !a_lt_b && !a_eq_b;
			BR_LE:     br_o.taken = a_lt_b || a_eq_b;
			BR_LT:     br_o.taken = a_lt_b;
			BR_GE:     br_o.taken = !a_lt_b;
			default:   br_o.taken = 1'b0;
		endcase
	end

	// register target comes in on port 3
	assign br_o.target = br_ctrl_i.use_reg_target ? c_i : br_ctrl_i.imm_target;

endmodule

// ==== hdl/decode_pkg.sv ====
package decode_pkg;

	localparam int WORD_W        = 32;
	localparam int INST_W        = 64;
	localparam int REG_ADDR_W    = 5;
	localparam int LINK_REG      = 29;
	localparam int RETURN_OFFSET = 8;
	// depth of the execute-side buffer
	localparam int CREDITS       = 2;
	localparam int CREDIT_W      = $clog2(CREDITS + 1);

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [INST_W-1:0]     inst_t;

	typedef enum logic [3:0] {
		FORM_IMM = 4'h1,
		FORM_REG = 4'h2
	} form_e;

	typedef enum logic [7:0] {
		OP_OR   = 8'h01,
		OP_AND  = 8'h02,
		OP_XOR  = 8'h03,
		OP_NOT  = 8'h04,
		OP_SHL  = 8'h05,
		OP_SHR  = 8'h06,
		OP_SAR  = 8'h07,
		OP_MOV  = 8'h08,
		OP_MOVZ = 8'h09,
		OP_MOVN = 8'h0A,
		OP_ADD  = 8'h0B,
		OP_SUB  = 8'h0C,
		OP_JMP  = 8'h10,
		OP_JE   = 8'h11,
		OP_JNE  = 8'h12,
		OP_JG   = 8'h13,
		OP_JNG  = 8'h14,
		OP_JL   = 8'h15,
		OP_JNL  = 8'h16,
		OP_CALL = 8'h17
	} op_e;

	// same code as the low five opcode bits
	typedef enum logic [4:0] {
		ALU_NOP  = 5'h00,
		ALU_OR   = 5'h01,
		ALU_AND  = 5'h02,
		ALU_XOR  = 5'h03,
		ALU_NOT  = 5'h04,
		ALU_SHL  = 5'h05,
		ALU_SHR  = 5'h06,
		ALU_SAR  = 5'h07,
		ALU_MOV  = 5'h08,
		ALU_MOVZ = 5'h09,
		ALU_MOVN = 5'h0A,
		ALU_ADD  = 5'h0B,
		ALU_SUB  = 5'h0C,
		ALU_JMP  = 5'h10,
		ALU_JE   = 5'h11,
		ALU_JNE  = 5'h12,
		ALU_JG   = 5'h13,
		ALU_JNG  = 5'h14,
		ALU_JL   = 5'h15,
		ALU_JNL  = 5'h16,
		ALU_CALL = 5'h17
	} aluop_e;

	typedef enum logic [2:0] {
		SEL_NOP,
		SEL_LOGIC,
		SEL_SHIFT,
		SEL_MOV,
		SEL_ARITH,
		SEL_JUMP,
		SEL_CALL
	} alusel_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_ALWAYS,
		BR_EQ,
		BR_NE,
		BR_GT,
		BR_LE,
		BR_LT,
		BR_GE
	} br_kind_e;

	typedef struct packed {
		logic      re1;
		reg_addr_t raddr1;
		logic      re2;
		reg_addr_t raddr2;
		logic      re3;
		reg_addr_t raddr3;
	} rd_req_t;

	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
	} fwd_t;

	typedef struct packed {
		aluop_e    aluop;
		alusel_e   alusel;
		word_t     op1;
		word_t     op2;
		reg_addr_t wd;
		logic      wreg;
	} exe_op_t;

	typedef struct packed {
		br_kind_e kind;
		word_t    imm_target;
		logic     use_reg_target;
	} br_ctrl_t;

	typedef struct packed {
		logic  taken;
		word_t target;
	} br_out_t;

endpackage

// ==== hdl/id_ex_reg.sv ====
`timescale 1ns/1ns

module id_ex_reg (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                inst_valid_i,
	input  logic                credit_return_i,
	input  decode_pkg::exe_op_t exe_op_i,
	input  decode_pkg::br_out_t br_i,
	output logic                inst_ready_o,
	output logic                out_valid_o,
	output decode_pkg::exe_op_t exe_op_o,
	output decode_pkg::br_out_t br_o
);

	import decode_pkg::*;

	logic [CREDIT_W-1:0] credit_q;
	logic                valid_q;
	logic                accept;
	exe_op_t             exe_op_q;
	br_out_t             br_q;

	assign inst_ready_o = (credit_q != '0);
	assign accept       = inst_valid_i && inst_ready_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			credit_q <= CREDIT_W'(CREDITS);
			valid_q  <= 1'b0;
		end else begin
			valid_q <= accept;
			// take and return in one cycle cancel out
			case ({accept, credit_return_i})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			exe_op_q <= exe_op_i;
			br_q     <= br_i;
		end
	end

	assign out_valid_o  = valid_q;
	assign exe_op_o     = exe_op_q;
	assign br_o.taken   = br_q.taken && valid_q;
	assign br_o.target  = br_q.target;

endmodule

// ==== hdl/id_stage.sv ====
`timescale 1ns/1ns

module id_stage (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 inst_valid_i,
	input  decode_pkg::inst_t    inst_i,
	input  decode_pkg::word_t    pc_i,
	output decode_pkg::rd_req_t  rd_req_o,
	input  decode_pkg::word_t    rf_data1_i,
	input  decode_pkg::word_t    rf_data2_i,
	input  decode_pkg::word_t    rf_data3_i,
	input  decode_pkg::fwd_t     ex_fwd_i,
	input  decode_pkg::fwd_t     mem_fwd_i,
	input  logic                 credit_return_i,
	output logic                 inst_ready_o,
	output logic                 out_valid_o,
	output decode_pkg::exe_op_t  exe_op_o,
	output decode_pkg::br_out_t  br_o
);

	import decode_pkg::*;

	word_t    rs1_val;
	word_t    rs2_val;
	word_t    rs3_val;
	exe_op_t  exe_op_d;
	br_ctrl_t br_ctrl;
	br_out_t  br_d;

	inst_decoder u_decoder (
		.inst_i    (inst_i),
		.pc_i      (pc_i),
		.rs1_val_i (rs1_val),
		.rs2_val_i (rs2_val),
		.rd_req_o  (rd_req_o),
		.exe_op_o  (exe_op_d),
		.br_ctrl_o (br_ctrl)
	);

	operand_fwd u_fwd1 (
		.addr_i    (rd_req_o.raddr1),
		.en_i      (rd_req_o.re1),
		.rf_data_i (rf_data1_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.value_o   (rs1_val)
	);

	operand_fwd u_fwd2 (
		.addr_i    (rd_req_o.raddr2),
		.en_i      (rd_req_o.re2),
		.rf_data_i (rf_data2_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.value_o   (rs2_val)
	);

	// port 3 only carries a conditional jump target
	operand_fwd u_fwd3 (
		.addr_i    (rd_req_o.raddr3),
		.en_i      (rd_req_o.re3),
		.rf_data_i (rf_data3_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.value_o   (rs3_val)
	);

	branch_resolve u_branch (
		.br_ctrl_i (br_ctrl),
		.a_i       (rs1_val),
		.b_i       (rs2_val),
		.c_i       (rs3_val),
		.br_o      (br_d)
	);

	id_ex_reg u_id_ex (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.inst_valid_i    (inst_valid_i),
		.credit_return_i (credit_return_i),
		.exe_op_i        (exe_op_d),
		.br_i            (br_d),
		.inst_ready_o    (inst_ready_o),
		.out_valid_o     (out_valid_o),
		.exe_op_o        (exe_op_o),
		.br_o            (br_o)
	);

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder (
	input  decode_pkg::inst_t    inst_i,
	input  decode_pkg::word_t    pc_i,
	input  decode_pkg::word_t    rs1_val_i,
	input  decode_pkg::word_t    rs2_val_i,
	output decode_pkg::rd_req_t  rd_req_o,
	output decode_pkg::exe_op_t  exe_op_o,
	output decode_pkg::br_ctrl_t br_ctrl_o
);

	import decode_pkg::*;

	form_e     form;
	op_e       op;
	reg_addr_t field_a;
	reg_addr_t field_b;
	reg_addr_t field_c;
	word_t     imm;
	word_t     mov_imm;
	word_t     jmp_target;
	logic      is_imm;
	logic      is_reg;
	logic      inst_ok;

	assign form       = form_e'(inst_i[63:60]);
	assign op         = op_e'(inst_i[59:52]);
	assign field_a    = inst_i[51:47];
	assign field_b    = inst_i[46:42];
	assign field_c    = inst_i[41:37];
	assign imm        = inst_i[41:10];
	assign mov_imm    = inst_i[46:15];
	assign jmp_target = inst_i[51:20];
	assign is_imm     = (form == FORM_IMM);
	assign is_reg     = (form == FORM_REG);

	// read requests depend on the instruction alone
	always_comb begin
		rd_req_o = '0;
		if (is_imm || is_reg) begin
			case (op)
				OP_OR, OP_AND, OP_XOR, OP_NOT, OP_SHL, OP_SHR, OP_SAR,
				OP_MOV, OP_MOVZ, OP_MOVN, OP_ADD, OP_SUB: begin
					// mov immediate sits on top of field B
					rd_req_o.re1    = !(is_imm && op == OP_MOV);
					rd_req_o.raddr1 = field_b;
					rd_req_o.re2    = is_reg;
					rd_req_o.raddr2 = field_c;
				end
				OP_JE, OP_JNE, OP_JG, OP_JNG, OP_JL, OP_JNL: begin
					rd_req_o.re1    = 1'b1;
					rd_req_o.raddr1 = field_a;
					rd_req_o.re2    = 1'b1;
					rd_req_o.raddr2 = field_b;
					rd_req_o.re3    = is_reg;
					rd_req_o.raddr3 = field_c;
				end
				OP_JMP, OP_CALL: begin
					rd_req_o.re1    = is_reg;
					rd_req_o.raddr1 = field_a;
				end
				default: rd_req_o = '0;
			endcase
		end
	end

	always_comb begin
		inst_ok                   = is_imm || is_reg;
		exe_op_o.aluop            = aluop_e'(inst_i[56:52]);
		exe_op_o.alusel           = SEL_NOP;
		exe_op_o.op1              = rs1_val_i;
		exe_op_o.op2              = is_reg ? rs2_val_i : imm;
		exe_op_o.wd               = field_a;
		exe_op_o.wreg             = 1'b0;
		br_ctrl_o.kind            = BR_NONE;
		br_ctrl_o.imm_target      = imm;
		br_ctrl_o.use_reg_target  = 1'b0;
		case (op)
			OP_OR, OP_AND, OP_XOR, OP_NOT: begin
				exe_op_o.alusel = SEL_LOGIC;
				exe_op_o.wreg   = 1'b1;
			end
			OP_SHL, OP_SHR, OP_SAR: begin
				exe_op_o.alusel = SEL_SHIFT;
				exe_op_o.wreg   = 1'b1;
			end
			OP_MOV: begin
				exe_op_o.alusel = SEL_MOV;
				exe_op_o.op1    = is_imm ? mov_imm : rs1_val_i;
				exe_op_o.wreg   = 1'b1;
			end
			OP_MOVZ, OP_MOVN: begin
				exe_op_o.alusel = SEL_MOV;
				exe_op_o.wreg   = (rs1_val_i == '0) ^ (op == OP_MOVN);
			end
			OP_ADD, OP_SUB: begin
				exe_op_o.alusel = SEL_ARITH;
				exe_op_o.wreg   = 1'b1;
			end
			OP_JMP: begin
				exe_op_o.alusel      = SEL_JUMP;
				br_ctrl_o.kind       = BR_ALWAYS;
				br_ctrl_o.imm_target = is_reg ? rs1_val_i : jmp_target;
			end
			OP_JE, OP_JNE, OP_JG, OP_JNG, OP_JL, OP_JNL: begin
				exe_op_o.alusel          = SEL_JUMP;
				br_ctrl_o.use_reg_target = is_reg;
				case (op)
					OP_JE:   br_ctrl_o.kind = BR_EQ;
					OP_JNE:  br_ctrl_o.kind = BR_NE;
					OP_JG:   br_ctrl_o.kind = BR_GT;
					OP_JNG:  br_ctrl_o.kind = BR_LE;
					OP_JL:   br_ctrl_o.kind = BR_LT;
					default: br_ctrl_o.kind = BR_GE;
				endcase
			end
			OP_CALL: begin
				// return address goes to the link register
				exe_op_o.alusel      = SEL_CALL;
				exe_op_o.op1         = pc_i + word_t'(RETURN_OFFSET);
				exe_op_o.wd          = reg_addr_t'(LINK_REG);
				exe_op_o.wreg        = 1'b1;
				br_ctrl_o.kind       = BR_ALWAYS;
				br_ctrl_o.imm_target = is_reg ? rs1_val_i : jmp_target;
			end
			default: inst_ok = 1'b0;
		endcase
		if (!inst_ok) begin
			exe_op_o  = '{aluop: ALU_NOP, alusel: SEL_NOP, default: '0};
			br_ctrl_o = '{kind: BR_NONE, default: '0};
		end
	end

endmodule

// ==== hdl/operand_fwd.sv ====
`timescale 1ns/1ns

module operand_fwd (
	input  decode_pkg::reg_addr_t addr_i,
	input  logic                  en_i,
	input  decode_pkg::word_t     rf_data_i,
	input  decode_pkg::fwd_t      ex_fwd_i,
	input  decode_pkg::fwd_t      mem_fwd_i,
	output decode_pkg::word_t     value_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
	assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

	// youngest result wins
	always_comb begin
		if (!en_i)
			value_o = '0;
		else if (ex_hit)
			value_o = ex_fwd_i.wdata;
		else if (mem_hit)
			value_o = mem_fwd_i.wdata;
		else
			value_o = rf_data_i;
	end

endmodule

// ==== verif/tb_id_stage.sv ====
`timescale 1ns/1ns

module tb_id_stage;

	import decode_pkg::*;

	localparam int WAIT_LIMIT = 20;

	logic    clk;
	logic    arst_n;
	logic    inst_valid;
	inst_t   inst;
	word_t   pc;
	rd_req_t rd_req;
	word_t   rf_data1;
	word_t   rf_data2;
	word_t   rf_data3;
	fwd_t    ex_fwd;
	fwd_t    mem_fwd;
	logic    credit_return;
	logic    inst_ready;
	logic    out_valid;
	exe_op_t exe_op;
	br_out_t br;

	word_t rf [32];
	int    seed = 31028;
	int    err_cnt = 0;
	int    check_cnt = 0;
	int    accept_cnt = 0;
	int    outv_cnt = 0;
	logic  accept_last = 1'b0;

	id_stage u_id_stage (
		.clk             (clk),
		.arst_n_i        (arst_n),
		.inst_valid_i    (inst_valid),
		.inst_i          (inst),
		.pc_i            (pc),
		.rd_req_o        (rd_req),
		.rf_data1_i      (rf_data1),
		.rf_data2_i      (rf_data2),
		.rf_data3_i      (rf_data3),
		.ex_fwd_i        (ex_fwd),
		.mem_fwd_i       (mem_fwd),
		.credit_return_i (credit_return),
		.inst_ready_o    (inst_ready),
		.out_valid_o     (out_valid),
		.exe_op_o        (exe_op),
		.br_o            (br)
	);

	// register file answers in the same cycle
	assign rf_data1 = rf[rd_req.raddr1];
	assign rf_data2 = rf[rd_req.raddr2];
	assign rf_data3 = rf[rd_req.raddr3];

	always #4 clk = ~clk;

	// each output pulse follows an acceptance by one cycle
	always @(negedge clk) begin
		if (out_valid !== accept_last) begin
			err_cnt++;
			$display("error: out_valid_o = %h, expected %h", out_valid, accept_last);
		end
		if (!out_valid && br.taken !== 1'b0) begin
			err_cnt++;
			$display("error: br_o.taken = %h, expected %h", br.taken, 1'b0);
		end
		if (out_valid)
			outv_cnt++;
		accept_last = arst_n && inst_valid && inst_ready;
		if (accept_last)
			accept_cnt++;
	end

	function automatic word_t random_word();
		return $random(seed);
	endfunction

	function automatic reg_addr_t pick_reg();
		return reg_addr_t'($random(seed));
	endfunction

	function automatic inst_t build_inst(logic [3:0] form, logic [7:0] op, reg_addr_t a,
			reg_addr_t b, word_t low);
		return {form, op, a, b, low, 10'h0};
	endfunction

	// register value as decode should see it after bypassing
	function automatic word_t fwd_value(reg_addr_t addr);
		if (ex_fwd.wreg && ex_fwd.wd == addr)
			return ex_fwd.wdata;
		if (mem_fwd.wreg && mem_fwd.wd == addr)
			return mem_fwd.wdata;
		return rf[addr];
	endfunction

	function automatic rd_req_t enabled_only(rd_req_t r);
		rd_req_t m;
		m = r;
		if (!m.re1)
			m.raddr1 = '0;
		if (!m.re2)
			m.raddr2 = '0;
		if (!m.re3)
			m.raddr3 = '0;
		return m;
	endfunction

	// ports each opcode should read with addresses kept only where enabled
	function automatic rd_req_t expect_rd_req(inst_t in);
		rd_req_t    r;
		logic [7:0] op;
		logic       reg_form;
		r        = '0;
		op       = in[59:52];
		reg_form = (in[63:60] == 4'h2);
		if (in[63:60] != 4'h1 && !reg_form)
			op = 8'h00;
		if (op >= 8'h01 && op <= 8'h0C) begin
			r.re1    = !(op == 8'h08 && !reg_form);
			r.raddr1 = in[46:42];
			r.re2    = reg_form;
			r.raddr2 = in[41:37];
		end else if (op >= 8'h11 && op <= 8'h16) begin
			r.re1    = 1'b1;
			r.raddr1 = in[51:47];
			r.re2    = 1'b1;
			r.raddr2 = in[46:42];
			r.re3    = reg_form;
			r.raddr3 = in[41:37];
		end else if (op == 8'h10 || op == 8'h17) begin
			r.re1    = reg_form;
			r.raddr1 = in[51:47];
		end
		return enabled_only(r);
	endfunction

	// mask bit 0 checks op1, bit 1 op2, bit 2 wd and bit 3 the target
	task automatic predict(input inst_t in, input word_t pc_val, output exe_op_t e,
			output br_out_t b, output logic [3:0] mask);
		logic [7:0] op;
		reg_addr_t  fa;
		reg_addr_t  fb;
		logic       reg_form;
		logic       alu;
		word_t      va;
		word_t      vb;
		op       = in[59:52];
		fa       = in[51:47];
		fb       = in[46:42];
		reg_form = (in[63:60] == 4'h2);
		alu      = 1'b0;
		e        = '0;
		b        = '0;
		mask     = 4'b0000;
		if (in[63:60] != 4'h1 && !reg_form)
			op = 8'h00;
		case (op)
			8'h01, 8'h02, 8'h03, 8'h04: e.alusel = SEL_LOGIC;
			8'h05, 8'h06, 8'h07: e.alusel = SEL_SHIFT;
			8'h08, 8'h09, 8'h0A: e.alusel = SEL_MOV;
			8'h0B, 8'h0C: e.alusel = SEL_ARITH;
			8'h10: begin
				e.alusel = SEL_JUMP;
				b.taken  = 1'b1;
				b.target = reg_form ? fwd_value(fa) : in[51:20];
				mask     = 4'b1000;
			end
			8'h11, 8'h12, 8'h13, 8'h14, 8'h15, 8'h16: begin
				e.alusel = SEL_JUMP;
				va       = fwd_value(fa);
				vb       = fwd_value(fb);
				case (op)
					8'h11: b.taken = (va == vb);
					8'h12: b.taken = (va != vb);
					8'h13: b.taken = (va > vb);
					8'h14: b.taken = (va <= vb);
					8'h15: b.taken = (va < vb);
					default: b.taken = (va >= vb);
				endcase
				b.target = reg_form ? fwd_value(in[41:37]) : in[41:10];
				mask     = 4'b1000;
			end
			8'h17: begin
				e.alusel = SEL_CALL;
				e.op1    = pc_val + word_t'(RETURN_OFFSET);
				e.wd     = reg_addr_t'(LINK_REG);
				e.wreg   = 1'b1;
				b.taken  = 1'b1;
				b.target = reg_form ? fwd_value(fa) : in[51:20];
				mask     = 4'b1101;
			end
			default: e.alusel = SEL_NOP;
		endcase
		alu = (e.alusel == SEL_LOGIC) || (e.alusel == SEL_SHIFT) ||
			(e.alusel == SEL_MOV) || (e.alusel == SEL_ARITH);
		if (alu) begin
			e.op1  = (op == 8'h08 && !reg_form) ? in[46:15] : fwd_value(fb);
			e.op2  = reg_form ? fwd_value(in[41:37]) : in[41:10];
			e.wd   = fa;
			e.wreg = 1'b1;
			if (op == 8'h09)
				e.wreg = (e.op1 == '0);
			if (op == 8'h0A)
				e.wreg = (e.op1 != '0);
			mask = 4'b0111;
		end
		if (e.alusel != SEL_NOP)
			e.aluop = aluop_e'(op[4:0]);
	endtask

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	task automatic run_inst(input inst_t in, input word_t pc_val);
		exe_op_t    e;
		br_out_t    b;
		logic [3:0] mask;
		int         wait_cnt;
		@(posedge clk);
		inst_valid <= 1'b1;
		inst       <= in;
		pc         <= pc_val;
		wait_cnt = 0;
		@(negedge clk);
		while (!inst_ready && wait_cnt < WAIT_LIMIT) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!inst_ready) begin
			err_cnt++;
			$display("timeout: inst_ready_o stayed low for inst %h", in);
		end
		compare_word("rd_req_o", 32'(enabled_only(rd_req)), 32'(expect_rd_req(in)));
		predict(in, pc_val, e, b, mask);
		@(posedge clk);
		inst_valid <= 1'b0;
		wait_cnt = 0;
		@(negedge clk);
		while (!out_valid && wait_cnt < WAIT_LIMIT) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!out_valid) begin
			err_cnt++;
			$display("timeout: no output for inst %h", in);
		end else begin
			compare_word("exe_op_o.aluop", 32'(exe_op.aluop), 32'(e.aluop));
			compare_word("exe_op_o.alusel", 32'(exe_op.alusel), 32'(e.alusel));
			compare_word("exe_op_o.wreg", 32'(exe_op.wreg), 32'(e.wreg));
			compare_word("br_o.taken", 32'(br.taken), 32'(b.taken));
			if (mask[0])
				compare_word("exe_op_o.op1", exe_op.op1, e.op1);
			if (mask[1])
				compare_word("exe_op_o.op2", exe_op.op2, e.op2);
			if (mask[2])
				compare_word("exe_op_o.wd", 32'(exe_op.wd), 32'(e.wd));
			if (mask[3])
				compare_word("br_o.target", br.target, b.target);
		end
		// execute frees its entry again
		@(posedge clk);
		credit_return <= 1'b1;
		@(posedge clk);
		credit_return <= 1'b0;
	endtask

	task automatic reset_values();
		@(negedge clk);
		compare_word("out_valid_o", 32'(out_valid), 32'h0);
		compare_word("inst_ready_o", 32'(inst_ready), 32'h1);
		compare_word("br_o.taken", 32'(br.taken), 32'h0);
	endtask

	task automatic alu_forms();
		int op;
		int form;
		for (op = 1; op <= 12; op++) begin
			if (op < 8 || op > 10) begin
				for (form = 1; form <= 2; form++)
					run_inst(build_inst(4'(form), 8'(op), pick_reg(), pick_reg(), random_word()),
						random_word());
			end
		end
	endtask

	task automatic forwarding_priority();
		inst_t in;
		int    k;
		in = build_inst(4'h2, 8'h0B, 5'd3, 5'd5, {5'd6, 27'h0});
		for (k = 0; k < 4; k++) begin
			@(posedge clk);
			case (k)
				0: begin
					ex_fwd  <= '{wreg: 1'b1, wd: 5'd5, wdata: random_word()};
					mem_fwd <= '{wreg: 1'b1, wd: 5'd5, wdata: random_word()};
				end
				1: begin
					ex_fwd  <= '{wreg: 1'b0, wd: 5'd5, wdata: random_word()};
					mem_fwd <= '{wreg: 1'b1, wd: 5'd5, wdata: random_word()};
				end
				2: begin
					ex_fwd  <= '{wreg: 1'b0, wd: 5'd5, wdata: random_word()};
					mem_fwd <= '{wreg: 1'b0, wd: 5'd5, wdata: random_word()};
				end
				default: begin
					ex_fwd  <= '{wreg: 1'b1, wd: 5'd6, wdata: random_word()};
					mem_fwd <= '{wreg: 1'b1, wd: 5'd5, wdata: random_word()};
				end
			endcase
			run_inst(in, random_word());
		end
		@(posedge clk);
		ex_fwd  <= '0;
		mem_fwd <= '0;
	endtask

	task automatic cond_jumps();
		int        op;
		int        form;
		int        pair;
		reg_addr_t a;
		reg_addr_t b;
		word_t     lo;
		word_t     hi;
		for (op = 8'h11; op <= 8'h16; op++) begin
			for (form = 1; form <= 2; form++) begin
				for (pair = 0; pair < 4; pair++) begin
					a  = pick_reg();
					b  = a ^ 5'h01;
					lo = random_word() & 32'h7fff_ffff;
					// top bit set so a signed compare would get it wrong
					hi = lo | 32'h8000_0000;
					@(posedge clk);
					case (pair)
						0: begin
							rf[a] <= random_word();
							rf[b] <= random_word();
						end
						1: begin
							rf[a] <= lo;
							rf[b] <= lo;
						end
						2: begin
							rf[a] <= hi;
							rf[b] <= lo;
						end
						default: begin
							rf[a] <= lo;
							rf[b] <= hi;
						end
					endcase
					run_inst(build_inst(4'(form), 8'(op), a, b, random_word()), random_word());
				end
			end
		end
		run_inst(build_inst(4'h1, 8'h10, pick_reg(), pick_reg(), random_word()), random_word());
		run_inst(build_inst(4'h2, 8'h10, pick_reg(), pick_reg(), random_word()), random_word());
	endtask

	task automatic moves_call_invalid();
		int        op;
		int        form;
		int        zero;
		reg_addr_t b;
		run_inst(build_inst(4'h1, 8'h08, pick_reg(), pick_reg(), random_word()), random_word());
		run_inst(build_inst(4'h2, 8'h08, pick_reg(), pick_reg(), random_word()), random_word());
		for (op = 9; op <= 10; op++) begin
			for (form = 1; form <= 2; form++) begin
				for (zero = 0; zero < 2; zero++) begin
					b = pick_reg();
					@(posedge clk);
					rf[b] <= (zero == 1) ? 32'h0 : (random_word() | 32'h1);
					run_inst(build_inst(4'(form), 8'(op), pick_reg(), b, random_word()),
						random_word());
				end
			end
		end
		run_inst(build_inst(4'h1, 8'h17, pick_reg(), pick_reg(), random_word()), random_word());
		run_inst(build_inst(4'h2, 8'h17, pick_reg(), pick_reg(), random_word()), random_word());
		// bad opcodes then bad forms
		run_inst(build_inst(4'h1, 8'h0D, pick_reg(), pick_reg(), random_word()), random_word());
		run_inst(build_inst(4'h2, 8'hFF, pick_reg(), pick_reg(), random_word()), random_word());
		run_inst(build_inst(4'h0, 8'h0B, pick_reg(), pick_reg(), random_word()), random_word());
		run_inst(build_inst(4'h3, 8'h17, pick_reg(), pick_reg(), random_word()), random_word());
	endtask

	task automatic credit_flow();
		int start;
		start = accept_cnt;
		@(posedge clk);
		inst_valid <= 1'b1;
		inst       <= build_inst(4'h2, 8'h0B, 5'd1, 5'd2, 32'h1800_0000);
		repeat (CREDITS + 4) @(posedge clk);
		@(negedge clk);
		if (accept_cnt - start != CREDITS) begin
			err_cnt++;
			$display("accepted %0d instructions without credits back, wanted %0d",
				accept_cnt - start, CREDITS);
		end
		compare_word("inst_ready_o", 32'(inst_ready), 32'h0);
		@(posedge clk);
		credit_return <= 1'b1;
		@(posedge clk);
		credit_return <= 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (accept_cnt - start != CREDITS + 1) begin
			err_cnt++;
			$display("one returned credit admitted %0d instructions instead of one",
				accept_cnt - start - CREDITS);
		end
		compare_word("inst_ready_o", 32'(inst_ready), 32'h0);
		@(posedge clk);
		inst_valid    <= 1'b0;
		credit_return <= 1'b1;
		repeat (CREDITS) @(posedge clk);
		credit_return <= 1'b0;
		@(negedge clk);
		compare_word("inst_ready_o", 32'(inst_ready), 32'h1);
	endtask

	initial begin
		int idx;
		clk           = 1'b0;
		arst_n        = 1'b0;
		inst_valid    = 1'b0;
		inst          = '0;
		pc            = '0;
		ex_fwd        = '0;
		mem_fwd       = '0;
		credit_return = 1'b0;
		for (idx = 0; idx < 32; idx++)
			rf[idx] = $random(seed);
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		reset_values();
		alu_forms();
		forwarding_priority();
		cond_jumps();
		moves_call_invalid();
		credit_flow();
		repeat (2) @(posedge clk);
		if (outv_cnt != accept_cnt) begin
			err_cnt++;
			$display("saw %0d output pulses for %0d accepted instructions", outv_cnt, accept_cnt);
		end
		$display("checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
